/* video_hal.f */
hw/hal_cfg_pkg.sv
hw/hal_video_pkg.sv
hw/umuldiv.sv
hw/uio_cmd_decoder.sv
hw/video_window_calc.sv
hw/sync_polarity_fix.sv
hw/csync_gen.sv
hw/video_hal_top.sv
tb/video_hal_checker.sv
tb/tb_video_hal.sv

/* tb/tb_video_hal.sv */
// Video HAL testbench
module tb_video_hal
	import hal_cfg_pkg::*, hal_video_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LINE_LEN   = 40;
	localparam int HS_LEN     = 4;
	localparam int FRAME_LNS  = 12;
	localparam int VS_LNS     = 2;
	localparam int FRAME_LEN  = LINE_LEN * FRAME_LNS;
	localparam int SETTLE     = 110;
	localparam int RAND_CASES = 12;

	logic        clk_sys;
	logic        rst_n;
	logic        io_uio, io_strobe;
	io_word_t    io_din, io_dout;
	aspect_t     ar_x, ar_y;
	logic        hs, vs, sync, vs_fix;
	window_t     window;
	logic        sync_chk, csync_exp;
	int          win_errs, read_errs, sync_errs;
	int          h_pos, v_line;
	logic [31:0] seed;
	video_mode_t mode_sh;
	scale_cfg_t  scale_sh;

	always #2 clk_sys = ~clk_sys;

	video_hal_top u_video_hal_top (
		.clk_sys     (clk_sys),
		.rst_n_i     (rst_n),
		.io_uio_i    (io_uio),
		.io_strobe_i (io_strobe),
		.io_din_i    (io_din),
		.io_dout_o   (io_dout),
		.video_ar_x_i(ar_x),
		.video_ar_y_i(ar_y),
		.hs_i        (hs),
		.vs_i        (vs),
		.sync_o      (sync),
		.vs_o        (vs_fix),
		.window_o    (window)
	);

	video_hal_checker u_checker (
		.clk_sys    (clk_sys),
		.rst_n_i    (rst_n),
		.io_uio_i   (io_uio),
		.io_dout_i  (io_dout),
		.window_i   (window),
		.hs_raw_i   (hs),
		.vs_raw_i   (vs),
		.sync_i     (sync),
		.vs_fix_i   (vs_fix),
		.sync_chk_i (sync_chk),
		.csync_en_i (csync_exp),
		.win_errs_o (win_errs),
		.read_errs_o(read_errs),
		.sync_errs_o(sync_errs)
	);

	// Raw sync with active-low pulses
	always @(posedge clk_sys) begin
		#1;
		h_pos = (h_pos == LINE_LEN - 1) ? 0 : h_pos + 1;
		if (h_pos == 0) begin
			v_line = (v_line == FRAME_LNS - 1) ? 0 : v_line + 1;
		end
		hs = (h_pos >= HS_LEN);
		vs = (v_line >= VS_LNS);
	end

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic abort_run(input string why);
		$display("Timeout: %s", why);
		$display("** FAIL **");
		$finish;
	endtask

	task automatic wait_clocks(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic wait_first_window();
		int n;
		n = 0;
		while (window == '0 && n < 200) begin
			@(posedge clk_sys);
			#1;
			n = n + 1;
		end
		if (window == '0) begin
			abort_run("no display window after reset");
		end
	endtask

	// Normalized vsync high while the raw input is low
	task automatic wait_vs_pulse();
		int n;
		n = 0;
		while (!(vs_fix && !vs) && n < 4 * FRAME_LEN) begin
			@(posedge clk_sys);
			#1;
			n = n + 1;
		end
		if (!(vs_fix && !vs)) begin
			abort_run("vsync never came out active high");
		end
	endtask

	////////////////////
	// Host channel
	task automatic send_word(input io_word_t w);
		@(posedge clk_sys);
		#1;
		io_din    = w;
		io_strobe = 1'b1;
		@(posedge clk_sys);
		#1;
		io_strobe = 1'b0;
	endtask

	task automatic begin_cmd(input cmd_t c);
		@(posedge clk_sys);
		#1;
		io_uio = 1'b1;
		send_word({8'h00, c});
	endtask

	task automatic end_cmd();
		@(posedge clk_sys);
		#1;
		io_uio = 1'b0;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic set_mode(input coord_t w, input coord_t h, input logic rep);
		begin_cmd(CMD_MODE);
		u_checker.check_dout(MODE_ACK);
		send_word({rep, 3'b000, w});
		repeat (3) send_word('0);
		send_word({4'h0, h});
		end_cmd();
		mode_sh = '{width: w, height: h, pixel_rep: rep};
	endtask

	task automatic set_vset(input coord_t v);
		begin_cmd(CMD_VSET);
		send_word({4'h0, v});
		end_cmd();
		scale_sh.vset = v;
	endtask

	task automatic set_hset(input logic fs, input coord_t h);
		begin_cmd(CMD_HSET);
		send_word({fs, 3'b000, h});
		end_cmd();
		scale_sh.freescale = fs;
		scale_sh.hset      = h;
	endtask

	task automatic set_arc(input aspect_t a1x, input aspect_t a1y, input aspect_t a2x,
		input aspect_t a2y);
		begin_cmd(CMD_ARC);
		send_word({3'b000, a1x});
		send_word({3'b000, a1y});
		send_word({3'b000, a2x});
		send_word({3'b000, a2y});
		end_cmd();
		scale_sh.arc1x = a1x;
		scale_sh.arc1y = a1y;
		scale_sh.arc2x = a2x;
		scale_sh.arc2y = a2y;
	endtask

	task automatic set_csync(input logic en);
		begin_cmd(CMD_CFG);
		send_word({12'h000, en, 3'b000});
		end_cmd();
	endtask

	task automatic read_aspect();
		begin_cmd(CMD_ARREAD);
		send_word('0);
		u_checker.check_readback(0, scale_sh, ar_x, ar_y);
		send_word('0);
		u_checker.check_readback(1, scale_sh, ar_x, ar_y);
		end_cmd();
	endtask

	task automatic set_core_ar(input aspect_t x, input aspect_t y);
		@(posedge clk_sys);
		#1;
		ar_x = x;
		ar_y = y;
	endtask

	task automatic settle_check();
		wait_clocks(SETTLE);
		u_checker.check_window(mode_sh, scale_sh, ar_x, ar_y);
	endtask

	initial begin
		clk_sys   = 1'b0;
		rst_n     = 1'b0;
		io_uio    = 1'b0;
		io_strobe = 1'b0;
		io_din    = '0;
		ar_x      = '0;
		ar_y      = '0;
		hs        = 1'b1;
		vs        = 1'b1;
		h_pos     = 0;
		v_line    = 0;
		sync_chk  = 1'b0;
		csync_exp = 1'b0;
		seed      = 32'hb447_f303;
		mode_sh   = '{width: DEF_WIDTH, height: DEF_HEIGHT, pixel_rep: 1'b0};
		scale_sh  = '0;
		repeat (2) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		wait_first_window();
		settle_check();

		////////////////////
		// Directed windows
		set_core_ar(13'd4, 13'd3);
		settle_check();
		u_checker.compare_coord("window_o.hmin", 12'd240, window.hmin);
		u_checker.compare_coord("window_o.hmax", 12'd1679, window.hmax);
		u_checker.compare_coord("window_o.vmin", 12'd0, window.vmin);
		u_checker.compare_coord("window_o.vmax", 12'd1079, window.vmax);
		set_vset(12'd720);
		settle_check();
		set_hset(1'b0, 12'd1280);
		settle_check();
		set_hset(1'b1, 12'd1280);
		settle_check();
		set_mode(12'd960, 12'd1080, 1'b1);
		settle_check();
		set_vset(12'd0);
		set_hset(1'b0, 12'd0);
		set_mode(DEF_WIDTH, DEF_HEIGHT, 1'b0);

		// Presets, the second one a literal 800x600
		set_arc(13'd16, 13'd9, 13'h1320, 13'h1258);
		for (int i = 1; i <= 3; i++) begin
			set_core_ar(aspect_t'(i), 13'd0);
			settle_check();
			read_aspect();
		end
		set_arc(13'd0, 13'd0, 13'd0, 13'd0);

		////////////////////
		// Random modes and aspects
		for (int i = 0; i < RAND_CASES; i++) begin
			seed = lcg_step(seed);
			set_mode(coord_t'(seed[10:0]) + 12'd640, coord_t'(seed[20:11]) + 12'd200,
				seed[31]);
			seed = lcg_step(seed);
			set_vset(seed[27] ? coord_t'(seed[10:0]) : 12'd0);
			set_hset(seed[29] & seed[30], seed[28] ? seed[11:0] : 12'd0);
			set_core_ar(aspect_t'(seed[16:12]), aspect_t'(seed[21:17]));
			settle_check();
			read_aspect();
		end

		// Acknowledge, then closed channel
		begin_cmd(CMD_MODE);
		u_checker.check_dout(MODE_ACK);
		end_cmd();
		u_checker.check_dout('0);

		////////////////////
		// Sync path
		wait_vs_pulse();
		sync_chk = 1'b1;
		wait_clocks(2 * FRAME_LEN);
		sync_chk = 1'b0;
		set_csync(1'b1);
		csync_exp = 1'b1;
		wait_clocks(4);
		sync_chk = 1'b1;
		wait_clocks(2 * FRAME_LEN);
		sync_chk = 1'b0;

		$display("Errors: window %0d, readback %0d, sync %0d", win_errs, read_errs, sync_errs);
		if (win_errs + read_errs + sync_errs == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* tb/video_hal_checker.sv */
// Video HAL checker
module video_hal_checker
	import hal_cfg_pkg::*, hal_video_pkg::*;
(
	input  logic     clk_sys,
	input  logic     rst_n_i,
	input  logic     io_uio_i,
	input  io_word_t io_dout_i,
	input  window_t  window_i,
	input  logic     hs_raw_i,
	input  logic     vs_raw_i,
	input  logic     sync_i,
	input  logic     vs_fix_i,
	input  logic     sync_chk_i,
	input  logic     csync_en_i,
	output int       win_errs_o,
	output int       read_errs_o,
	output int       sync_errs_o
);
	timeunit 1ns;
	timeprecision 1ps;

	logic hs_prev, vs_prev, uio_prev;

	initial begin
		win_errs_o  = 0;
		read_errs_o = 0;
		sync_errs_o = 0;
		uio_prev    = 1'b1;
	end

	////////////////////
	// Reference model

	// Selected aspect as {arxy, arx, ary}
	function automatic logic [24:0] ref_aspect(input scale_cfg_t s, input aspect_t cx,
		input aspect_t cy);
		aspect_t px, py;
		if (cy != '0) begin
			px = cx;
			py = cy;
		end else if (cx == aspect_t'(1)) begin
			px = s.arc1x;
			py = s.arc1y;
		end else if (cx == aspect_t'(2)) begin
			px = s.arc2x;
			py = s.arc2y;
		end else begin
			px = '0;
			py = '0;
		end
		return {px[12] | py[12], px[11:0], py[11:0]};
	endfunction

	function automatic window_t ref_window(input video_mode_t m, input scale_cfg_t s,
		input aspect_t cx, input aspect_t cy);
		coord_t      hh, hw, w, h, vw, vh, diff;
		coord_t      ax, ay;
		logic        axy;
		logic [23:0] prod;
		window_t     win;
		hh = (s.vset != '0 && s.vset < m.height) ? s.vset : m.height;
		hw = (s.hset != '0 && s.hset < m.width) ? s.hset : m.width;
		hw = hw << m.pixel_rep;
		{axy, ax, ay} = ref_aspect(s, cx, cy);
		if (s.freescale || ax == '0 || ay == '0) begin
			w = hw;
			h = hh;
		end else if (axy) begin
			w = ax;
			h = ay;
		end else begin
			// Quotient truncated to 12 bits
			prod = hh * ax;
			w    = coord_t'(prod / ay);
			prod = hw * ay;
			h    = coord_t'(prod / ax);
		end
		vw = ((w < hw) ? w : hw) >> m.pixel_rep;
		vh = (h < hh) ? h : hh;
		diff     = m.width - vw;
		win.hmin = diff >> 1;
		win.hmax = win.hmin + vw - 12'd1;
		diff     = m.height - vh;
		win.vmin = diff >> 1;
		win.vmax = win.vmin + vh - 12'd1;
		return win;
	endfunction

	////////////////////
	// Compare tasks
	task automatic compare_coord(input string name, input coord_t want, input coord_t got);
		if (got !== want) begin
			$display("CHECK FAILED %s expected %h actual %h", name, want, got);
			win_errs_o = win_errs_o + 1;
		end
	endtask

	task automatic check_window(input video_mode_t m, input scale_cfg_t s, input aspect_t cx,
		input aspect_t cy);
		window_t want;
		want = ref_window(m, s, cx, cy);
		compare_coord("window_o.hmin", want.hmin, window_i.hmin);
		compare_coord("window_o.hmax", want.hmax, window_i.hmax);
		compare_coord("window_o.vmin", want.vmin, window_i.vmin);
		compare_coord("window_o.vmax", want.vmax, window_i.vmax);
	endtask

	task automatic check_dout(input io_word_t want);
		if (io_dout_i !== want) begin
			$display("CHECK FAILED io_dout_o expected %h actual %h", want, io_dout_i);
			read_errs_o = read_errs_o + 1;
		end
	endtask

	task automatic check_readback(input int idx, input scale_cfg_t s, input aspect_t cx,
		input aspect_t cy);
		logic [24:0] sel;
		io_word_t    want;
		sel = ref_aspect(s, cx, cy);
		if (idx == 0) begin
			want = {3'b000, sel[24], sel[23:12]};
		end else begin
			want = {3'b000, sel[24], sel[11:0]};
		end
		check_dout(want);
	endtask

	task automatic report_sync(input string name, input logic want, input logic got);
		$display("CHECK FAILED %s expected %h actual %h", name, want, got);
		sync_errs_o = sync_errs_o + 1;
	endtask

	// Sync path and idle readback, sampled mid-cycle
	always @(negedge clk_sys) begin
		if (sync_chk_i) begin
			if (vs_fix_i !== !vs_raw_i) begin
				report_sync("vs_o", !vs_raw_i, vs_fix_i);
			end
			if (!csync_en_i && sync_i !== !hs_raw_i) begin
				report_sync("sync_o", !hs_raw_i, sync_i);
			end
			// Composite sync lags the normalized hsync by one clock
			if (csync_en_i && !vs_prev && sync_i !== hs_prev) begin
				report_sync("sync_o", hs_prev, sync_i);
			end
		end
		if (rst_n_i && !uio_prev) begin
			check_dout('0);
		end
		hs_prev  <= !hs_raw_i;
		vs_prev  <= !vs_raw_i;
		uio_prev <= io_uio_i;
	end

endmodule

/* hw/video_hal_top.sv */
// Video HAL top level
module video_hal_top
	import hal_cfg_pkg::*, hal_video_pkg::*;
(
	input  logic     clk_sys,
	input  logic     rst_n_i,
	input  logic     io_uio_i,
	input  logic     io_strobe_i,
	input  io_word_t io_din_i,
	output io_word_t io_dout_o,
	input  aspect_t  video_ar_x_i,
	input  aspect_t  video_ar_y_i,
	input  logic     hs_i,
	input  logic     vs_i,
	output logic     sync_o,
	output logic     vs_o,
	output window_t  window_o
);

	video_mode_t mode;
	scale_cfg_t  scale;
	logic        csync_en;
	coord_t      arx, ary;
	logic        arxy;
	logic        hs_fix, csync;

	uio_cmd_decoder u_cmd_decoder (
		.clk_sys    (clk_sys),
		.rst_n_i    (rst_n_i),
		.io_uio_i   (io_uio_i),
		.io_strobe_i(io_strobe_i),
		.io_din_i   (io_din_i),
		.io_dout_o  (io_dout_o),
		.mode_o     (mode),
		.scale_o    (scale),
		.csync_en_o (csync_en),
		.arx_i      (arx),
		.ary_i      (ary),
		.arxy_i     (arxy)
	);

	video_window_calc u_window_calc (
		.clk_sys     (clk_sys),
		.rst_n_i     (rst_n_i),
		.mode_i      (mode),
		.scale_i     (scale),
		.video_ar_x_i(video_ar_x_i),
		.video_ar_y_i(video_ar_y_i),
		.arx_o       (arx),
		.ary_o       (ary),
		.arxy_o      (arxy),
		.window_o    (window_o)
	);

	////////////////////
	// Sync path
	sync_polarity_fix u_hs_fix (
		.clk_sys(clk_sys),
		.rst_n_i(rst_n_i),
		.sync_i (hs_i),
		.sync_o (hs_fix)
	);

	sync_polarity_fix u_vs_fix (
		.clk_sys(clk_sys),
		.rst_n_i(rst_n_i),
		.sync_i (vs_i),
		.sync_o (vs_o)
	);

	csync_gen u_csync (
		.clk_sys(clk_sys),
		.rst_n_i(rst_n_i),
		.hsync_i(hs_fix),
		.vsync_i(vs_o),
		.csync_o(csync)
	);

	assign sync_o = csync_en ? csync : hs_fix;

endmodule

/* hw/csync_gen.sv */
// Composite sync generator
module csync_gen
	import hal_video_pkg::*;
(
	input  logic clk_sys,
	input  logic rst_n_i,
	input  logic hsync_i,
	input  logic vsync_i,
	output logic csync_o
);

	logic      hsync_d;
	logic      cs_hs, cs_vs;
	sync_cnt_t h_cnt;
	sync_cnt_t line_len, hs_len;

	// Vsync inverts the serrated pulse
	assign csync_o = cs_vs ^ cs_hs;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			hsync_d  <= 1'b0;
			cs_hs    <= 1'b0;
			cs_vs    <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
		end else begin
			hsync_d <= hsync_i;
			h_cnt   <= h_cnt + 1'b1;

			// Line length and hsync width
			if (hsync_d != hsync_i) begin
				h_cnt <= '0;
				if (hsync_i) begin
					line_len <= h_cnt - hs_len;
				end else begin
					hs_len <= h_cnt;
				end
			end

			if (!vsync_i) begin
				cs_hs <= hsync_i;
			end else if (h_cnt == line_len) begin
				cs_hs <= 1'b1;
			end else if (hsync_i && !hsync_d) begin
				cs_hs <= 1'b0;
			end

			cs_vs <= vsync_i;
		end
	end

endmodule

/* hw/sync_polarity_fix.sv */
// Sync polarity normalizer
module sync_polarity_fix
	import hal_video_pkg::*;
(
	input  logic clk_sys,
	input  logic rst_n_i,
	input  logic sync_i,
	output logic sync_o
);

	logic      sync_d;
	logic      pol;
	sync_cnt_t cnt;
	sync_cnt_t hi_len, lo_len;

	// Pulse is the shorter phase
	assign sync_o = sync_i ^ pol;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			sync_d <= 1'b0;
			pol    <= 1'b0;
			cnt    <= '0;
			hi_len <= '0;
			lo_len <= '0;
		end else begin
			sync_d <= sync_i;
			if (sync_d != sync_i) begin
				cnt <= '0;
				// Store the length of the phase that just ended
				if (sync_i) begin
					lo_len <= cnt;
				end else begin
					hi_len <= cnt;
				end
			end else if (cnt != '1) begin
				cnt <= cnt + 1'b1;
			end
			pol <= hi_len > lo_len;
		end
	end

endmodule

/* hw/video_window_calc.sv */
// Display window calculator
module video_window_calc
	import hal_video_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n_i,
	input  video_mode_t mode_i,
	input  scale_cfg_t  scale_i,
	input  aspect_t     video_ar_x_i,
	input  aspect_t     video_ar_y_i,
	output coord_t      arx_o,
	output coord_t      ary_o,
	output logic        arxy_o,
	output window_t     window_o
);

	calc_state_e state;

	coord_t hh, hw, hw_base;
	coord_t wcalc, hcalc;
	coord_t videow, videoh;
	coord_t hoff, voff;

	logic   md_start, md_busy;
	coord_t md_mul1, md_mul2, md_div, md_res;

	umuldiv u_muldiv (
		.clk_sys (clk_sys),
		.rst_n_i (rst_n_i),
		.start_i (md_start),
		.busy_o  (md_busy),
		.mul1_i  (md_mul1),
		.mul2_i  (md_mul2),
		.div_i   (md_div),
		.result_o(md_res)
	);

	always_comb begin
		hw_base = (scale_i.hset != '0 && scale_i.hset < mode_i.width) ? scale_i.hset
			: mode_i.width;
		// Centring offsets
		hoff = (mode_i.width - videow) >> 1;
		voff = (mode_i.height - videoh) >> 1;
	end

	////////////////////
	// Output size and aspect, tracked every clock
	always_ff @(posedge clk_sys) begin
		hh <= (scale_i.vset != '0 && scale_i.vset < mode_i.height) ? scale_i.vset
			: mode_i.height;
		hw <= hw_base << mode_i.pixel_rep;

		if (video_ar_y_i != '0) begin
			arx_o  <= video_ar_x_i[AR_LIT_BIT-1:0];
			ary_o  <= video_ar_y_i[AR_LIT_BIT-1:0];
			arxy_o <= video_ar_x_i[AR_LIT_BIT] | video_ar_y_i[AR_LIT_BIT];
		end else if (video_ar_x_i == aspect_t'(1)) begin
			arx_o  <= scale_i.arc1x[AR_LIT_BIT-1:0];
			ary_o  <= scale_i.arc1y[AR_LIT_BIT-1:0];
			arxy_o <= scale_i.arc1x[AR_LIT_BIT] | scale_i.arc1y[AR_LIT_BIT];
		end else if (video_ar_x_i == aspect_t'(2)) begin
			arx_o  <= scale_i.arc2x[AR_LIT_BIT-1:0];
			ary_o  <= scale_i.arc2y[AR_LIT_BIT-1:0];
			arxy_o <= scale_i.arc2x[AR_LIT_BIT] | scale_i.arc2y[AR_LIT_BIT];
		end else begin
			arx_o  <= '0;
			ary_o  <= '0;
			arxy_o <= 1'b0;
		end
	end

	////////////////////
	// Window FSM
	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			state    <= IDLE_SEL;
			md_start <= 1'b0;
			window_o <= '0;
		end else begin
			md_start <= 1'b0;
			case (state)
				IDLE_SEL: begin
					if (scale_i.freescale || arx_o == '0 || ary_o == '0) begin
						wcalc <= hw;
						hcalc <= hh;
						state <= CLAMP;
					end else if (arxy_o) begin
						// Literal picture size
						wcalc <= arx_o;
						hcalc <= ary_o;
						state <= CLAMP;
					end else begin
						state <= MUL_W;
					end
				end
				MUL_W: begin
					md_mul1  <= hh;
					md_mul2  <= arx_o;
					md_div   <= ary_o;
					md_start <= 1'b1;
					state    <= WAIT_W;
				end
				WAIT_W: begin
					if (!md_start && !md_busy) begin
						wcalc <= md_res;
						state <= MUL_H;
					end
				end
				MUL_H: begin
					md_mul1  <= hw;
					md_mul2  <= ary_o;
					md_div   <= arx_o;
					md_start <= 1'b1;
					state    <= WAIT_H;
				end
				WAIT_H: begin
					if (!md_start && !md_busy) begin
						hcalc <= md_res;
						state <= CLAMP;
					end
				end
				CLAMP: begin
					videow <= ((wcalc > hw) ? hw : wcalc) >> mode_i.pixel_rep;
					videoh <= (hcalc > hh) ? hh : hcalc;
					state  <= CENTER;
				end
				CENTER: begin
					window_o <= '{hmin: hoff, hmax: hoff + videow - 1'b1,
						vmin: voff, vmax: voff + videoh - 1'b1};
					state    <= IDLE_SEL;
				end
				default: state <= IDLE_SEL;
			endcase
		end
	end

	// FSM only starts the divider once it is idle
	a_start_idle: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		md_start |-> !md_busy);

endmodule

/* hw/uio_cmd_decoder.sv */
// Host command decoder
module uio_cmd_decoder
	import hal_cfg_pkg::*, hal_video_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst_n_i,
	input  logic        io_uio_i,
	input  logic        io_strobe_i,
	input  io_word_t    io_din_i,
	output io_word_t    io_dout_o,
	output video_mode_t mode_o,
	output scale_cfg_t  scale_o,
	output logic        csync_en_o,
	input  coord_t      arx_i,
	input  coord_t      ary_i,
	input  logic        arxy_i
);

	logic      has_cmd;
	cmd_t      cmd;
	word_cnt_t cnt;

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			has_cmd    <= 1'b0;
			cmd        <= '0;
			cnt        <= '0;
			io_dout_o  <= '0;
			mode_o     <= '{width: DEF_WIDTH, height: DEF_HEIGHT, pixel_rep: 1'b0};
			scale_o    <= '0;
			csync_en_o <= 1'b0;
		end else if (!io_uio_i) begin
			// Channel closed, any open command is dropped
			has_cmd   <= 1'b0;
			cmd       <= '0;
			io_dout_o <= '0;
		end else if (io_strobe_i) begin
			io_dout_o <= '0;
			if (!has_cmd) begin
				// Command word
				has_cmd <= 1'b1;
				cmd     <= cmd_t'(io_din_i);
				cnt     <= '0;
				if (cmd_t'(io_din_i) == CMD_MODE) begin
					io_dout_o <= MODE_ACK;
				end
			end else begin
				// Data words, counter stops at the top
				if (cnt != '1) begin
					cnt <= cnt + 1'b1;
				end
				case (cmd)
					CMD_CFG: begin
						csync_en_o <= io_din_i[CFG_CSYNC_BIT];
					end
					CMD_MODE: begin
						if (cnt == MODE_WORD_WIDTH) begin
							mode_o.pixel_rep <= io_din_i[FLAG_BIT];
							mode_o.width     <= coord_t'(io_din_i);
						end
						if (cnt == MODE_WORD_HEIGHT) begin
							mode_o.height <= coord_t'(io_din_i);
						end
					end
					CMD_VSET: begin
						scale_o.vset <= coord_t'(io_din_i);
					end
					CMD_HSET: begin
						scale_o.freescale <= io_din_i[FLAG_BIT];
						scale_o.hset      <= coord_t'(io_din_i);
					end
					CMD_ARC: begin
						// Two presets, x then y
						case (cnt)
							8'd0: scale_o.arc1x <= aspect_t'(io_din_i);
							8'd1: scale_o.arc1y <= aspect_t'(io_din_i);
							8'd2: scale_o.arc2x <= aspect_t'(io_din_i);
							8'd3: scale_o.arc2y <= aspect_t'(io_din_i);
							default: ;
						endcase
					end
					CMD_ARREAD: begin
						if (cnt == ARREAD_WORD_X) begin
							io_dout_o <= io_word_t'({arxy_i, arx_i});
						end
						if (cnt == ARREAD_WORD_Y) begin
							io_dout_o <= io_word_t'({arxy_i, ary_i});
						end
					end
					default: ;
				endcase
			end
		end
	end

	// Closed channel reads back zero on the next clock
	a_dout_idle: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		!io_uio_i |=> io_dout_o == '0);

endmodule

/* hw/umuldiv.sv */
// Sequential multiply-divide
module umuldiv
	import hal_video_pkg::*;
(
	input  logic   clk_sys,
	input  logic   rst_n_i,
	input  logic   start_i,
	output logic   busy_o,
	input  coord_t mul1_i,
	input  coord_t mul2_i,
	input  coord_t div_i,
	output coord_t result_o
);

	coord_t     op1, op2, dsr, rem;
	prod_t      dvd;
	logic [3:0] step;

	logic [$bits(coord_t):0] t1, t2;
	coord_t                  r1, r2;
	logic                    q1, q2;

	// Two restoring steps per clock
	always_comb begin
		t1 = {rem, dvd[$bits(prod_t)-1]};
		q1 = t1 >= {1'b0, dsr};
		r1 = q1 ? coord_t'(t1 - {1'b0, dsr}) : coord_t'(t1);
		t2 = {r1, dvd[$bits(prod_t)-2]};
		q2 = t2 >= {1'b0, dsr};
		r2 = q2 ? coord_t'(t2 - {1'b0, dsr}) : coord_t'(t2);
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n_i) begin
			busy_o   <= 1'b0;
			step     <= '0;
			result_o <= '0;
		end else if (start_i) begin
			op1    <= mul1_i;
			op2    <= mul2_i;
			dsr    <= div_i;
			step   <= '0;
			busy_o <= 1'b1;
		end else if (busy_o) begin
			step <= step + 1'b1;
			if (step == '0) begin
				// Multiply first, then divide the full product
				dvd      <= op1 * op2;
				rem      <= '0;
				result_o <= '0;
			end else begin
				dvd      <= dvd << 2;
				rem      <= r2;
				// Only the low quotient bits are kept
				result_o <= {result_o[$bits(coord_t)-3:0], q1, q2};
				if (step == 4'(MD_STEPS)) begin
					busy_o <= 1'b0;
				end
			end
		end
	end

endmodule

/* hw/hal_video_pkg.sv */
// Video geometry types
package hal_video_pkg;

	// Pixel or line count
	typedef logic [11:0] coord_t;

	// Aspect component, top bit flags a literal size
	typedef logic [12:0] aspect_t;
	localparam int AR_LIT_BIT = 12;

	// Full product inside the multiply-divide unit
	typedef logic [2*$bits(coord_t)-1:0] prod_t;

	// Two quotient bits per division step
	localparam int MD_STEPS = $bits(prod_t) / 2;

	// Sync phase and line length counters
	typedef logic [23:0] sync_cnt_t;

	typedef struct packed {
		coord_t width;
		coord_t height;
		logic   pixel_rep;
	} video_mode_t;

	typedef struct packed {
		coord_t  vset;
		coord_t  hset;
		logic    freescale;
		aspect_t arc1x;
		aspect_t arc1y;
		aspect_t arc2x;
		aspect_t arc2y;
	} scale_cfg_t;

	typedef struct packed {
		coord_t hmin;
		coord_t hmax;
		coord_t vmin;
		coord_t vmax;
	} window_t;

	// Mode after reset
	localparam coord_t DEF_WIDTH  = 12'd1920;
	localparam coord_t DEF_HEIGHT = 12'd1080;

	typedef enum logic [2:0] {
		IDLE_SEL,
		MUL_W,
		WAIT_W,
		MUL_H,
		WAIT_H,
		CLAMP,
		CENTER
	} calc_state_e;

endpackage

/* hw/hal_cfg_pkg.sv */
// Host command definitions
package hal_cfg_pkg;

	// Host channel data word
	typedef logic [15:0] io_word_t;

	// Command code, carried in the low byte of the first word
	typedef logic [7:0] cmd_t;

	// Data word index within a command
	typedef logic [7:0] word_cnt_t;

	////////////////////
	// Command codes
	////////////////////
	localparam cmd_t CMD_CFG    = 8'h01;
	localparam cmd_t CMD_MODE   = 8'h20;
	localparam cmd_t CMD_VSET   = 8'h27;
	localparam cmd_t CMD_HSET   = 8'h37;
	localparam cmd_t CMD_ARC    = 8'h3A;
	localparam cmd_t CMD_ARREAD = 8'h40;

	////////////////////
	// Word layout
	////////////////////
	localparam int CFG_CSYNC_BIT = 3;

	// Pixel repetition in mode word 0, free-scale in hset word
	localparam int FLAG_BIT = 15;

	localparam word_cnt_t MODE_WORD_WIDTH  = 8'd0;
	localparam word_cnt_t MODE_WORD_HEIGHT = 8'd4;

	localparam word_cnt_t ARREAD_WORD_X = 8'd0;
	localparam word_cnt_t ARREAD_WORD_Y = 8'd1;

	// Returned after the CMD_MODE command word
	localparam io_word_t MODE_ACK = 16'd3;

endpackage
